//--- rtl/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width of the core
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_REG_COUNT 32

// bits needed to index one register
`define RV_REG_ADDR_W 5

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// RV_REG_COUNT must equal 2 ** RV_REG_ADDR_W

`endif

//--- rtl/rv_isa_pkg.sv
`include "rv_settings.svh"

package rv_isa_pkg;

  // one data or address word
  typedef logic [`RV_XLEN-1:0] word_t;

  // register index, x0 to x31
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  // raw 32-bit instruction as fetched
  typedef logic [31:0] inst_t;

  // funct3 field, bits 14:12
  typedef logic [2:0] funct3_t;

  // major opcodes, bits 6:0
  // only the ones the core executes are listed
  typedef enum logic [6:0] {
    // addi and the rest of OP-IMM
    op_imm    = 7'b001_0011,
    // load upper immediate
    op_lui    = 7'b011_0111,
    // pc-relative upper immediate
    op_auipc  = 7'b001_0111,
    // pc-relative jump and link
    op_jal    = 7'b110_1111,
    // register-relative jump and link
    op_jalr   = 7'b110_0111,
    // ecall / ebreak / csr space
    op_system = 7'b111_0011
  } opcode_e;

  // funct3 of addi inside OP-IMM
  // other OP-IMM funct3 values are not executed
  parameter funct3_t FUNCT3_ADDI = 3'b000;

endpackage

//--- rtl/rv_core_pkg.sv
package rv_core_pkg;

  // first adder operand
  // zero for lui, rs1 for addi / jalr, pc for auipc / jal
  typedef enum logic [1:0] {
    op_a_zero = 2'd0,
    op_a_rs1  = 2'd1,
    op_a_pc   = 2'd2
  } op_a_sel_e;

  // write-back source
  // link value pc + 4 only for jal / jalr
  typedef enum logic {
    wb_sum = 1'b0,
    wb_pc4 = 1'b1
  } wb_sel_e;

  // next pc source
  // target is the adder sum with bit 0 cleared
  typedef enum logic {
    pc_plus4  = 1'b0,
    pc_target = 1'b1
  } pc_sel_e;

endpackage

//--- rtl/rv_ctrl_if.sv
`timescale 1ns/1ns

interface rv_ctrl_if;

  // register indices
  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rd;

  // selected immediate, already sign extended
  rv_isa_pkg::word_t imm;

  // datapath steering
  rv_core_pkg::op_a_sel_e op_a;
  rv_core_pkg::wb_sel_e wb_sel;
  rv_core_pkg::pc_sel_e pc_sel;

  // already low for x0 and for no-ops
  logic reg_wen;
  logic is_ebreak;

  modport decoder (
    output rs1, rd, imm, op_a, wb_sel, pc_sel, reg_wen, is_ebreak
  );

  modport datapath (
    input rs1, rd, imm, op_a, wb_sel, pc_sel, reg_wen, is_ebreak
  );

endinterface

//--- rtl/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
  input rv_isa_pkg::inst_t inst,
  rv_ctrl_if.decoder ctrl
);

  // the one system encoding the core acts on
  localparam rv_isa_pkg::inst_t EBREAK_INST = 32'h0010_0073;

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::word_t imm_i;
  rv_isa_pkg::word_t imm_u;
  rv_isa_pkg::word_t imm_j;
  logic writes_rd;

  // fixed field positions
  assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign rd = inst[11:7];

  assign ctrl.rs1 = inst[19:15];
  assign ctrl.rd = rd;

  // I type, 12 bits sign extended
  assign imm_i = {{20{inst[31]}}, inst[31:20]};

  // U type, upper 20 bits, low 12 zero
  assign imm_u = {inst[31:12], 12'h000};

  // J type, scrambled 20 bits, bit 0 always zero
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // defaults make an unknown encoding a plain pc + 4 no-op
    ctrl.imm = imm_i;
    ctrl.op_a = rv_core_pkg::op_a_zero;
    ctrl.wb_sel = rv_core_pkg::wb_sum;
    ctrl.pc_sel = rv_core_pkg::pc_plus4;
    ctrl.is_ebreak = 1'b0;
    writes_rd = 1'b0;

    case (opcode)
      rv_isa_pkg::op_imm: begin
        // only addi, slti / xori / shifts etc fall through as no-ops
        if (funct3 == rv_isa_pkg::FUNCT3_ADDI) begin
          ctrl.op_a = rv_core_pkg::op_a_rs1;
          writes_rd = 1'b1;
        end
      end
      rv_isa_pkg::op_lui: begin
        // 0 + imm_u
        ctrl.imm = imm_u;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        ctrl.imm = imm_u;
        ctrl.op_a = rv_core_pkg::op_a_pc;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        ctrl.imm = imm_j;
        ctrl.op_a = rv_core_pkg::op_a_pc;
        ctrl.wb_sel = rv_core_pkg::wb_pc4;
        ctrl.pc_sel = rv_core_pkg::pc_target;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::op_jalr: begin
        // rs1 + imm_i, bit 0 dropped in the datapath
        ctrl.op_a = rv_core_pkg::op_a_rs1;
        ctrl.wb_sel = rv_core_pkg::wb_pc4;
        ctrl.pc_sel = rv_core_pkg::pc_target;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::op_system: begin
        // ecall and csr ops retire as no-ops
        ctrl.is_ebreak = (inst == EBREAK_INST);
      end
      default: begin
        // branches, loads, stores, R type
        writes_rd = 1'b0;
      end
    endcase
  end

  // x0 stays zero since it is never written
  assign ctrl.reg_wen = writes_rd && (rd != '0);

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_regfile (
  input logic clk,
  input logic rst_n,
  input rv_isa_pkg::reg_addr_t rs1_addr,
  input rv_isa_pkg::reg_addr_t rd_addr,
  input logic wen,
  input rv_isa_pkg::word_t wdata,
  output rv_isa_pkg::word_t rs1_data
);

  // x0 included, decoder keeps its write enable low
  rv_isa_pkg::word_t regs [`RV_REG_COUNT];

  // combinational read
  // a write in this cycle shows up on the next instruction
  assign rs1_data = regs[rs1_addr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // architectural state starts at zero
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[rd_addr] <= wdata;
    end
  end

endmodule

//--- rtl/rv_datapath.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_datapath (
  input logic clk,
  input logic rst_n,
  rv_ctrl_if.datapath ctrl,
  input logic inst_valid,
  output logic inst_ready,
  output rv_isa_pkg::word_t pc,
  output logic retire_valid,
  output logic retire_wen,
  output rv_isa_pkg::word_t retire_pc,
  output rv_isa_pkg::word_t retire_data,
  output rv_isa_pkg::reg_addr_t retire_rd,
  output logic halted
);

  rv_isa_pkg::word_t rs1_data;
  rv_isa_pkg::word_t op_a_val;
  rv_isa_pkg::word_t sum;
  rv_isa_pkg::word_t pc_plus4;
  rv_isa_pkg::word_t target;
  rv_isa_pkg::word_t wb_data;
  rv_isa_pkg::word_t next_pc;
  logic accept;
  logic wen;

  // accept whenever something is offered and not halted
  assign inst_ready = ~halted;
  assign accept = inst_valid & ~halted;

  // write only for an accepted instruction
  assign wen = accept & ctrl.reg_wen;

  rv_regfile regfile_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (ctrl.rs1),
    .rd_addr  (ctrl.rd),
    .wen      (wen),
    .wdata    (wb_data),
    .rs1_data (rs1_data)
  );

  // first operand of the single adder
  always_comb begin
    case (ctrl.op_a)
      rv_core_pkg::op_a_rs1: op_a_val = rs1_data;
      rv_core_pkg::op_a_pc: op_a_val = pc;
      default: op_a_val = '0;
    endcase
  end

  // second operand is always the immediate
  assign sum = op_a_val + ctrl.imm;
  assign pc_plus4 = pc + rv_isa_pkg::word_t'(4);

  // bit 0 cleared for jalr
  // jal targets are even already so one path serves both
  assign target = {sum[`RV_XLEN-1:1], 1'b0};

  // link value or adder result
  assign wb_data = (ctrl.wb_sel == rv_core_pkg::wb_pc4) ? pc_plus4 : sum;

  assign next_pc = (ctrl.pc_sel == rv_core_pkg::pc_target) ? target : pc_plus4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
      halted <= 1'b0;
    end else if (accept) begin
      // ebreak parks pc at its own address
      if (ctrl.is_ebreak) begin
        halted <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

  // retire port mirrors the instruction being accepted this cycle
  assign retire_valid = accept;
  assign retire_pc = pc;
  assign retire_wen = wen;
  assign retire_rd = ctrl.rd;
  assign retire_data = wb_data;

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top (
  input logic clk,
  input logic rst_n,
  output rv_isa_pkg::word_t pc,
  input rv_isa_pkg::inst_t inst,
  input logic inst_valid,
  output logic inst_ready,
  output logic retire_valid,
  output rv_isa_pkg::word_t retire_pc,
  output logic retire_wen,
  output rv_isa_pkg::reg_addr_t retire_rd,
  output rv_isa_pkg::word_t retire_data,
  output logic halted
);

  // decoded control, combinational from inst
  rv_ctrl_if ctrl_if ();

  rv_decoder decoder_i (
    .inst (inst),
    .ctrl (ctrl_if.decoder)
  );

  // pc, register file, adder and retire port
  rv_datapath datapath_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl         (ctrl_if.datapath),
    .inst_valid   (inst_valid),
    .inst_ready   (inst_ready),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire_wen   (retire_wen),
    .retire_pc    (retire_pc),
    .retire_data  (retire_data),
    .retire_rd    (retire_rd),
    .halted       (halted)
  );

endmodule

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module tb_rv_core;

  localparam int unsigned SEED = 32'h8f6d305a;
  // power-of-two program size keeps a slot index at 6 bits
  localparam int PROG_LEN = 64;
  localparam int PROG_AW = 6;
  localparam int VALID_PCT = 50;
  localparam int DRIVE_DELAY = 2;
  localparam int HALT_HOLD = 10;
  localparam int MAX_CYCLES = 4 * PROG_LEN + 100;

  // fixed slots inside the random program
  localparam int X0_IDX = 2;
  localparam int JAL_IDX = 10;
  localparam int JAL_DEST = 14;
  localparam int LINK_IDX = 30;
  localparam int JALR_DEST = 40;

  localparam rv_isa_pkg::inst_t EBREAK_WORD = 32'h0010_0073;
  localparam rv_isa_pkg::inst_t NOP_WORD = 32'h0000_0013;

  typedef rv_isa_pkg::word_t word_t;

  // expected outcome of one retired instruction
  typedef struct packed {
    logic wen;
    logic halt;
    rv_isa_pkg::reg_addr_t rd;
    word_t data;
    word_t next_pc;
  } expect_t;

  logic clk = 1'b0;
  logic rst_n;
  word_t pc;
  rv_isa_pkg::inst_t inst;
  logic inst_valid;
  logic inst_ready;
  logic retire_valid;
  word_t retire_pc;
  logic retire_wen;
  rv_isa_pkg::reg_addr_t retire_rd;
  word_t retire_data;
  logic halted;

  // slot n holds the instruction word at reset pc + 4n
  rv_isa_pkg::inst_t prog [0:PROG_LEN-1];

  // shadow state of the core, owned by the compare process
  word_t shadow_regs [`RV_REG_COUNT];
  word_t shadow_pc;
  logic exp_halted;

  logic checking;
  int cycle_count;

  rv_core_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc           (pc),
    .inst         (inst),
    .inst_valid   (inst_valid),
    .inst_ready   (inst_ready),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_wen   (retire_wen),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  // 40 ns period
  always #20 clk = ~clk;

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR %s expected %h got %h", name, exp, got);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // instruction encoders
  function automatic rv_isa_pkg::inst_t itype_word(input logic [11:0] imm,
      input rv_isa_pkg::reg_addr_t rs1, input logic [2:0] f3,
      input rv_isa_pkg::reg_addr_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_isa_pkg::inst_t utype_word(input logic [19:0] imm,
      input rv_isa_pkg::reg_addr_t rd, input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic rv_isa_pkg::inst_t jal_word(input rv_isa_pkg::reg_addr_t rd,
      input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  // addi, lui, auipc or an encoding the core must ignore
  function automatic rv_isa_pkg::inst_t random_inst();
    rv_isa_pkg::inst_t raw;
    int unsigned kind;
    raw = $urandom();
    kind = $urandom() % 4;
    case (kind)
      0: return itype_word(raw[31:20], raw[19:15], 3'b000, raw[11:7], 7'h13);
      1: return utype_word(raw[31:12], raw[11:7], 7'h37);
      2: return utype_word(raw[31:12], raw[11:7], 7'h17);
      default: begin
        kind = $urandom() % 6;
        case (kind)
          // OP-IMM other than addi
          0: return itype_word(raw[31:20], raw[19:15], 3'(1 + $urandom() % 7),
                               raw[11:7], 7'h13);
          1: return {raw[31:7], 7'h63};
          2: return {raw[31:7], 7'h33};
          3: return {raw[31:7], 7'h03};
          4: return {raw[31:7], 7'h23};
          // ecall
          default: return 32'h0000_0073;
        endcase
      end
    endcase
  endfunction

  task automatic build_program();
    word_t goal;
    word_t raw;
    for (int i = 0; i < PROG_LEN; i++) begin
      prog[i[PROG_AW-1:0]] = random_inst();
    end
    // write to x0 and read x0 back
    raw = $urandom();
    prog[X0_IDX] = itype_word(raw[31:20], raw[19:15], 3'b000, 5'd0, 7'h13);
    prog[X0_IDX + 1] = itype_word(raw[11:0], 5'd0, 3'b000, 5'(1 + $urandom() % 31), 7'h13);
    // forward jal over a few slots
    // link registers are never x0 so the link value is always seen
    raw = $urandom();
    prog[JAL_IDX] = jal_word(5'(1 + raw[11:7] % 31), 21'((JAL_DEST - JAL_IDX) * 4));
    // odd target in x5 so jalr has to drop bit 0
    goal = `RV_RESET_PC + word_t'(JALR_DEST * 4) + 32'd1;
    prog[LINK_IDX] = utype_word(goal[31:12] + {19'd0, goal[11]}, 5'd5, 7'h37);
    prog[LINK_IDX + 1] = itype_word(goal[11:0], 5'd5, 3'b000, 5'd5, 7'h13);
    prog[LINK_IDX + 2] = itype_word(12'd0, 5'd5, 3'b000, 5'(1 + raw[16:12] % 31), 7'h67);
    prog[PROG_LEN - 1] = EBREAK_WORD;
  endtask

  // word at addr or a nop outside the program
  function automatic rv_isa_pkg::inst_t fetch_word(input word_t addr);
    word_t off;
    off = addr - `RV_RESET_PC;
    if (off[1:0] == 2'b00 && off[31:PROG_AW+2] == '0) begin
      return prog[off[PROG_AW+1:2]];
    end
    return NOP_WORD;
  endfunction

  // expected result of one instruction by the ISA rules
  function automatic expect_t predict(input rv_isa_pkg::inst_t w, input word_t at);
    expect_t e;
    word_t src1;
    word_t imm_i;
    word_t imm_u;
    word_t imm_j;
    logic signed [11:0] i_off;
    logic signed [20:0] j_off;
    src1 = shadow_regs[w[19:15]];
    i_off = w[31:20];
    j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    imm_i = word_t'(i_off);
    imm_j = word_t'(j_off);
    imm_u = {w[31:12], 12'd0};
    e.wen = 1'b0;
    e.halt = 1'b0;
    e.rd = w[11:7];
    e.data = '0;
    e.next_pc = at + 32'd4;
    case (w[6:0])
      7'h13: begin
        if (w[14:12] == 3'b000) begin
          e.wen = 1'b1;
          e.data = src1 + imm_i;
        end
      end
      7'h37: begin
        e.wen = 1'b1;
        e.data = imm_u;
      end
      7'h17: begin
        e.wen = 1'b1;
        e.data = at + imm_u;
      end
      7'h6f: begin
        e.wen = 1'b1;
        e.data = at + 32'd4;
        e.next_pc = at + imm_j;
      end
      7'h67: begin
        e.wen = 1'b1;
        e.data = at + 32'd4;
        e.next_pc = (src1 + imm_i) & ~32'd1;
      end
      7'h73: e.halt = (w == EBREAK_WORD);
      default: e.wen = 1'b0;
    endcase
    // x0 is never written
    if (e.rd == '0) begin
      e.wen = 1'b0;
    end
    return e;
  endfunction

  task automatic drive_fetch(input logic valid);
    inst = fetch_word(pc);
    inst_valid = valid;
  endtask

  // mid-cycle compare when outputs have settled after the drive delay
  always @(negedge clk) begin : compare_proc
    expect_t e;
    rv_isa_pkg::inst_t cur;
    if (!rst_n) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        shadow_regs[i[4:0]] = '0;
      end
      shadow_pc = `RV_RESET_PC;
      exp_halted = 1'b0;
    end else if (checking) begin
      // pc holds still on idle and halted cycles
      check_value("pc", pc, shadow_pc);
      check_value("halted", word_t'(halted), word_t'(exp_halted));
      check_value("inst_ready", word_t'(inst_ready), word_t'(!exp_halted));
      check_value("retire_valid", word_t'(retire_valid), word_t'(inst_valid && !exp_halted));
      if (retire_valid) begin
        cur = fetch_word(shadow_pc);
        e = predict(cur, shadow_pc);
        check_value("retire_pc", retire_pc, shadow_pc);
        check_value("retire_wen", word_t'(retire_wen), word_t'(e.wen));
        if (e.wen) begin
          check_value("retire_rd", word_t'(retire_rd), word_t'(e.rd));
          check_value("retire_data", retire_data, e.data);
          shadow_regs[e.rd] = e.data;
        end
        // ebreak parks the pc at its own address
        if (e.halt) begin
          exp_halted = 1'b1;
        end else begin
          shadow_pc = e.next_pc;
        end
      end
    end
  end

  // run limit from program length
  always @(posedge clk) begin
    if (rst_n) begin
      cycle_count++;
      if (cycle_count > MAX_CYCLES) begin
        $display("TB FAILED");
        $fatal(1, "timeout, core did not finish within %0d cycles", MAX_CYCLES);
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    inst = '0;
    inst_valid = 1'b0;
    checking = 1'b0;
    cycle_count = 0;
    void'($urandom(SEED));
    build_program();
    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    // idle state before the first valid
    @(negedge clk);
    check_value("pc", pc, `RV_RESET_PC);
    check_value("inst_ready", word_t'(inst_ready), 32'd1);
    check_value("halted", word_t'(halted), 32'd0);
    check_value("retire_valid", word_t'(retire_valid), 32'd0);
    checking = 1'b1;
    while (!exp_halted) begin
      @(posedge clk);
      #DRIVE_DELAY;
      drive_fetch(($urandom() % 100) < VALID_PCT);
    end
    // keep offering after the halt
    repeat (HALT_HOLD) begin
      @(posedge clk);
      #DRIVE_DELAY;
      drive_fetch(1'b1);
    end
    @(negedge clk);
    #1;
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- tb.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/rv_ctrl_if.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_datapath.sv
rtl/rv_core_top.sv
testbench/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rv core testbench with verilator
# exit status is nonzero when the build fails or the testbench hits $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
  --top-module tb_rv_core \
  -Mdir obj_dir \
  -f tb.f \
  && ./obj_dir/Vtb_rv_core \
  || { echo "simulation failed"; exit 1; }

exit 0
